// ==== flist.f ====
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/fetcher.sv
verilog/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_tb -f flist.f -o cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error status, see sim.log"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	echo "PASS"
	exit 0
fi

echo "FAIL, see sim.log"
exit 1

// ==== tests/cpu_tb.sv ====
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int NUM_INSTR      = 400;
	localparam int RESET_CYCLES   = 5;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 100;

	logic     phi0;
	logic     rst;
	byte_t    rdata;
	mem_bus_t bus;
	logic     sync;

	byte_t mem [0:65535];

	// Opcode pool whose last three entries the core does not implement
	byte_t op_table [21] = '{
		OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM, OP_AND_IMM, OP_ORA_IMM,
		OP_EOR_IMM, OP_TAX, OP_TAY, OP_INX, OP_INY, OP_CLC, OP_SEC, OP_NOP,
		OP_STA_ABS, OP_STX_ABS, OP_STY_ABS, OP_JMP_ABS, 8'h02, 8'h5A, 8'hFF
	};

	logic [31:0] rng = 32'hd221;
	int          cycles = 0;

	// Reference model state
	byte_t m_a;
	byte_t m_x;
	byte_t m_y;
	logic  m_c;
	addr_t m_pc;
	addr_t end_pc;
	int    exp_cycles;
	int    cyc_count;
	logic  pend_we;
	addr_t pend_addr;
	byte_t pend_data;
	int    writes_expected;
	int    writes_seen;
	logic  first_sync;
	logic  at_end;
	logic  done;

	cpu_top u_dut (
		.phi0  (phi0),
		.rst   (rst),
		.rdata (rdata),
		.bus   (bus),
		.sync  (sync)
	);

	initial begin
		phi0 = 1'b0;
		forever #2 phi0 = ~phi0;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	assign rdata = mem[bus.addr];

	always @(posedge phi0) begin
		if (!rst && bus.we) begin
			mem[bus.addr] = bus.wdata;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic fill_memory();
		addr_t a;
		a = '0;
		do begin
			mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
			a = a + 16'd1;
		end while (a != 16'd0);
	endtask

	task automatic gen_program();
		addr_t      p;
		addr_t      tgt;
		byte_t      op;
		logic [4:0] idx;
		p = RESET_PC;
		for (int n = 0; n < NUM_INSTR - 1; n++) begin
			rng = xorshift(rng);
			idx = 5'(rng % 32'd21);
			op = op_table[idx];
			rng = xorshift(rng);
			mem[p] = op;
			case (op)
				OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM,
				OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
					mem[p + 16'd1] = rng[15:8];
					p = p + 16'd2;
				end
				OP_STA_ABS, OP_STX_ABS, OP_STY_ABS: begin
					mem[p + 16'd1] = rng[23:16];
					mem[p + 16'd2] = 8'h10;
					p = p + 16'd3;
				end
				OP_JMP_ABS: begin
					// Forward to the next slot keeps the listing linear
					tgt = p + 16'd3;
					mem[p + 16'd1] = tgt[7:0];
					mem[p + 16'd2] = tgt[15:8];
					p = p + 16'd3;
				end
				default: p = p + 16'd1;
			endcase
		end
		// Final jump to itself
		end_pc = p;
		mem[p] = OP_JMP_ABS;
		mem[p + 16'd1] = p[7:0];
		mem[p + 16'd2] = p[15:8];
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference instruction model stepped once per opcode fetch
	//////////////////////////////////////////////////////////////////////

	task automatic model_step();
		byte_t      op;
		byte_t      lo;
		byte_t      hi;
		logic [8:0] sum;
		op = mem[m_pc];
		lo = mem[m_pc + 16'd1];
		hi = mem[m_pc + 16'd2];
		exp_cycles = 2;
		m_pc = m_pc + 16'd1;
		case (op)
			OP_LDA_IMM: m_a = lo;
			OP_LDX_IMM: m_x = lo;
			OP_LDY_IMM: m_y = lo;
			OP_ADC_IMM: begin
				sum = {1'b0, m_a} + {1'b0, lo} + {8'd0, m_c};
				m_a = sum[7:0];
				m_c = sum[8];
			end
			OP_AND_IMM: m_a = m_a & lo;
			OP_ORA_IMM: m_a = m_a | lo;
			OP_EOR_IMM: m_a = m_a ^ lo;
			OP_TAX: m_x = m_a;
			OP_TAY: m_y = m_a;
			OP_INX: m_x = m_x + 8'd1;
			OP_INY: m_y = m_y + 8'd1;
			OP_CLC: m_c = 1'b0;
			OP_SEC: m_c = 1'b1;
			OP_STA_ABS, OP_STX_ABS, OP_STY_ABS: begin
				exp_cycles = 4;
				pend_we = 1'b1;
				pend_addr = {hi, lo};
				if (op == OP_STX_ABS) begin
					pend_data = m_x;
				end else if (op == OP_STY_ABS) begin
					pend_data = m_y;
				end else begin
					pend_data = m_a;
				end
				writes_expected++;
			end
			OP_JMP_ABS: begin
				exp_cycles = 3;
				m_pc = {hi, lo};
			end
			default: ;
		endcase
		// Immediate operand and absolute address bytes
		case (op)
			OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM,
			OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: m_pc = m_pc + 16'd1;
			OP_STA_ABS, OP_STX_ABS, OP_STY_ABS: m_pc = m_pc + 16'd2;
			default: ;
		endcase
	endtask

	task automatic check_cycle();
		if (first_sync) begin
			assert (sync) else fail_now("sync was not high in the first cycle after reset");
		end
		if (sync) begin
			if (!first_sync) begin
				assert (cyc_count == exp_cycles) else fail_now($sformatf(
					"ERROR instruction cycles got %0h expected %0h", cyc_count, exp_cycles));
				assert (!pend_we) else fail_now("a predicted store cycle never happened");
			end
			first_sync = 1'b0;
			assert (bus.addr == m_pc) else fail_now($sformatf(
				"ERROR bus.addr at sync got %h expected %h", bus.addr, m_pc));
			cyc_count = 1;
			if (at_end) begin
				done = 1'b1;
			end else begin
				at_end = (m_pc == end_pc);
				model_step();
			end
		end else begin
			cyc_count++;
		end
		if (bus.we) begin
			assert (pend_we) else fail_now($sformatf(
				"ERROR bus.we unexpected write bus.addr %h bus.wdata %h", bus.addr, bus.wdata));
			assert (bus.addr == pend_addr) else fail_now($sformatf(
				"ERROR bus.addr on write got %h expected %h", bus.addr, pend_addr));
			assert (bus.wdata == pend_data) else fail_now($sformatf(
				"ERROR bus.wdata got %h expected %h", bus.wdata, pend_data));
			pend_we = 1'b0;
			writes_seen++;
		end
	endtask

	always @(posedge phi0) begin
		cycles++;
		assert (cycles < TIMEOUT_CYCLES)
			else fail_now("timeout, the program never settled on its final jump");
	end

	initial begin
		rst = 1'b1;
		fill_memory();
		gen_program();
		m_a = '0;
		m_x = '0;
		m_y = '0;
		m_c = 1'b0;
		m_pc = RESET_PC;
		exp_cycles = 0;
		cyc_count = 0;
		pend_we = 1'b0;
		pend_addr = '0;
		pend_data = '0;
		writes_expected = 0;
		writes_seen = 0;
		first_sync = 1'b1;
		at_end = 1'b0;
		done = 1'b0;
		repeat (RESET_CYCLES) @(posedge phi0);
		#1;
		rst = 1'b0;
		while (!done) begin
			@(negedge phi0);
			check_cycle();
		end
		assert (writes_seen == writes_expected) else fail_now($sformatf(
			"ERROR write count got %0h expected %0h", writes_seen, writes_expected));
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/cpu_sva.sv ====
`default_nettype none

module cpu_sva import cpu_pkg::*; (
	input wire             phi0,
	input wire             rst,
	input wire             sync,
	input wire mem_bus_t   bus,
	input wire cpu_state_e state
);

	// A store cycle never fetches an opcode
	a_we_sync: assert property (@(posedge phi0) disable iff (rst) !(bus.we && sync))
		else $error("write strobe and sync high in the same cycle");

	// First cycle out of reset is an opcode fetch
	a_sync_after_rst: assert property (@(posedge phi0) $fell(rst) |-> sync)
		else $error("sync did not rise after reset");

	// Longest instruction leaves ST_OPCODE for three cycles
	a_state_return: assert property (@(posedge phi0) disable iff (rst)
		!(state != ST_OPCODE && $past(state, 1) != ST_OPCODE &&
		$past(state, 2) != ST_OPCODE && $past(state, 3) != ST_OPCODE))
		else $error("state stayed away from ST_OPCODE for four cycles");

endmodule

bind fetcher cpu_sva u_sva (
	.phi0  (phi0),
	.rst   (rst),
	.sync  (sync),
	.bus   (bus),
	.state (state)
);

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  wire         phi0,
	input  wire         rst,
	input  wire byte_t  rdata,
	output mem_bus_t    bus,
	output logic        sync
);

	//////////////////////////////////////////////////////////////////////
	// Internal connections
	//////////////////////////////////////////////////////////////////////

	micro_ctrl_t ctrl;
	byte_t       opcode;
	byte_t       operand;
	logic        exec;
	byte_t       store_data;

	// ALU datapath
	byte_t       alu_a;
	byte_t       alu_b;
	byte_t       result;
	logic        carry_in;
	logic        carry_out;

	fetcher fetch (
		.phi0       (phi0),
		.rst        (rst),
		.rdata      (rdata),
		.ctrl       (ctrl),
		.store_data (store_data),
		.bus        (bus),
		.sync       (sync),
		.opcode     (opcode),
		.operand    (operand),
		.exec       (exec)
	);

	decoder decode (
		.opcode (opcode),
		.ctrl   (ctrl)
	);

	register_file regs (
		.phi0       (phi0),
		.rst        (rst),
		.ctrl       (ctrl),
		.exec       (exec),
		.operand    (operand),
		.result     (result),
		.carry_out  (carry_out),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.carry_in   (carry_in),
		.store_data (store_data)
	);

	alu alu_core (
		.op        (ctrl.alu_op),
		.a         (alu_a),
		.b         (alu_b),
		.carry_in  (carry_in),
		.result    (result),
		.carry_out (carry_out)
	);

endmodule

`default_nettype wire

// ==== verilog/fetcher.sv ====
`default_nettype none

module fetcher import cpu_pkg::*; (
	input  wire         phi0,
	input  wire         rst,
	input  wire byte_t  rdata,
	input  wire micro_ctrl_t ctrl,
	input  wire byte_t  store_data,
	output mem_bus_t    bus,
	output logic        sync,
	output byte_t       opcode,
	output byte_t       operand,
	output logic        exec
);

	//////////////////////////////////////////////////////////////////////
	// Sequencer state
	//////////////////////////////////////////////////////////////////////

	cpu_state_e state;
	addr_t      pc;

	// Absolute address gathered from the two operand bytes
	addr_t      op_addr;

	always_ff @(posedge phi0) begin
		if (rst) begin
			state <= ST_OPCODE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				ST_OPCODE: begin
					pc    <= pc + 16'd1;
					state <= ST_OPERAND_LO;
				end
				ST_OPERAND_LO: begin
					// Implied re-reads the next opcode byte without consuming it
					if (ctrl.cls != CLS_IMPLIED) begin
						pc <= pc + 16'd1;
					end
					if (ctrl.cls == CLS_STORE_ABS || ctrl.cls == CLS_JMP_ABS) begin
						state <= ST_OPERAND_HI;
					end else begin
						state <= ST_OPCODE;
					end
				end
				ST_OPERAND_HI: begin
					if (ctrl.cls == CLS_JMP_ABS) begin
						pc    <= {rdata, op_addr[7:0]};
						state <= ST_OPCODE;
					end else begin
						pc    <= pc + 16'd1;
						state <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					state <= ST_OPCODE;
				end
				default: begin
					state <= ST_OPCODE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Opcode and operand address latches
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge phi0) begin
		if (sync) begin
			opcode <= rdata;
		end
		if (state == ST_OPERAND_LO) begin
			op_addr[7:0] <= rdata;
		end
		if (state == ST_OPERAND_HI) begin
			op_addr[15:8] <= rdata;
		end
	end

	// Immediate byte is on the bus in the execute cycle
	assign operand = rdata;

	assign exec = (state == ST_OPERAND_LO) &&
		(ctrl.cls == CLS_IMPLIED || ctrl.cls == CLS_IMM);

	// Opcode fetch marker held low in reset
	assign sync = (state == ST_OPCODE) && !rst;

	//////////////////////////////////////////////////////////////////////
	// Bus drive
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		bus.addr  = (state == ST_WRITE) ? op_addr : pc;
		bus.wdata = store_data;
		bus.we    = (state == ST_WRITE);
	end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none

module register_file import cpu_pkg::*; (
	input  wire         phi0,
	input  wire         rst,
	input  wire micro_ctrl_t ctrl,
	input  wire         exec,
	input  wire byte_t  operand,
	input  wire byte_t  result,
	input  wire         carry_out,
	output byte_t       alu_a,
	output byte_t       alu_b,
	output logic        carry_in,
	output byte_t       store_data
);

	byte_t reg_a;
	byte_t reg_x;
	byte_t reg_y;
	logic  carry;

	// Read port shared by both ALU operands and the store path
	function automatic byte_t read_reg(reg_sel_e sel);
		case (sel)
			REG_A:   return reg_a;
			REG_X:   return reg_x;
			REG_Y:   return reg_y;
			default: return operand;
		endcase
	endfunction

	always_comb begin
		alu_a      = read_reg(ctrl.dst_sel);
		alu_b      = read_reg(ctrl.src_sel);
		store_data = read_reg(ctrl.src_sel);
	end

	assign carry_in = carry;

	always_ff @(posedge phi0) begin
		if (rst) begin
			reg_a <= '0;
			reg_x <= '0;
			reg_y <= '0;
			carry <= 1'b0;
		end else if (exec) begin
			if (ctrl.reg_write) begin
				case (ctrl.dst_sel)
					REG_A:   reg_a <= result;
					REG_X:   reg_x <= result;
					REG_Y:   reg_y <= result;
					default: ;
				endcase
			end
			case (ctrl.carry_ctl)
				CARRY_ALU:   carry <= carry_out;
				CARRY_CLEAR: carry <= 1'b0;
				CARRY_SET:   carry <= 1'b1;
				default:     ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decoder.sv ====
`default_nettype none

module decoder import cpu_pkg::*; (
	input  wire byte_t  opcode,
	output micro_ctrl_t ctrl
);

	always_comb begin
		// Anything unlisted behaves as a two-cycle NOP
		ctrl.cls       = CLS_IMPLIED;
		ctrl.alu_op    = ALU_PASS;
		ctrl.src_sel   = REG_A;
		ctrl.dst_sel   = REG_A;
		ctrl.reg_write = 1'b0;
		ctrl.carry_ctl = CARRY_KEEP;

		case (opcode)
			// Immediate loads pass the operand through
			OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
				ctrl.cls       = CLS_IMM;
				ctrl.src_sel   = REG_IMM;
				ctrl.reg_write = 1'b1;
				if (opcode == OP_LDX_IMM) begin
					ctrl.dst_sel = REG_X;
				end else if (opcode == OP_LDY_IMM) begin
					ctrl.dst_sel = REG_Y;
				end
			end

			// Accumulator operations with the operand byte
			OP_ADC_IMM: begin
				ctrl.cls       = CLS_IMM;
				ctrl.alu_op    = ALU_ADC;
				ctrl.src_sel   = REG_IMM;
				ctrl.reg_write = 1'b1;
				ctrl.carry_ctl = CARRY_ALU;
			end
			OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
				ctrl.cls       = CLS_IMM;
				ctrl.src_sel   = REG_IMM;
				ctrl.reg_write = 1'b1;
				case (opcode)
					OP_AND_IMM: ctrl.alu_op = ALU_AND;
					OP_ORA_IMM: ctrl.alu_op = ALU_ORA;
					default:    ctrl.alu_op = ALU_EOR;
				endcase
			end

			// Transfers from A
			OP_TAX, OP_TAY: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel   = (opcode == OP_TAX) ? REG_X : REG_Y;
			end

			// Index increments read and write the same register
			OP_INX, OP_INY: begin
				ctrl.alu_op    = ALU_INC;
				ctrl.reg_write = 1'b1;
				ctrl.src_sel   = (opcode == OP_INX) ? REG_X : REG_Y;
				ctrl.dst_sel   = (opcode == OP_INX) ? REG_X : REG_Y;
			end

			OP_CLC: ctrl.carry_ctl = CARRY_CLEAR;
			OP_SEC: ctrl.carry_ctl = CARRY_SET;
			OP_NOP: ;

			// Stores name the register to put on wdata
			OP_STA_ABS: ctrl.cls = CLS_STORE_ABS;
			OP_STX_ABS: begin
				ctrl.cls     = CLS_STORE_ABS;
				ctrl.src_sel = REG_X;
			end
			OP_STY_ABS: begin
				ctrl.cls     = CLS_STORE_ABS;
				ctrl.src_sel = REG_Y;
			end

			OP_JMP_ABS: ctrl.cls = CLS_JMP_ABS;

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
	input  wire alu_op_e op,
	input  wire byte_t   a,
	input  wire byte_t   b,
	input  wire          carry_in,
	output byte_t        result,
	output logic         carry_out
);

	// Ninth bit is the carry of the add
	logic [DATA_W:0] sum;

	assign sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, carry_in};

	always_comb begin
		carry_out = 1'b0;
		case (op)
			ALU_PASS: result = b;
			ALU_ADC: begin
				result    = sum[DATA_W-1:0];
				carry_out = sum[DATA_W];
			end
			ALU_AND: result = a & b;
			ALU_ORA: result = a | b;
			ALU_EOR: result = a ^ b;
			// Wraps without touching carry as INX and INY do
			ALU_INC: result = a + 8'd1;
			default: result = b;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths and basic types
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// First opcode fetch after reset
	localparam addr_t RESET_PC = 16'h0200;

	//////////////////////////////////////////////////////////////////////
	// Standard 6502 opcode encodings
	//////////////////////////////////////////////////////////////////////

	// Immediate loads
	localparam byte_t OP_LDA_IMM = 8'hA9;
	localparam byte_t OP_LDX_IMM = 8'hA2;
	localparam byte_t OP_LDY_IMM = 8'hA0;

	// Immediate ALU operations on A
	localparam byte_t OP_ADC_IMM = 8'h69;
	localparam byte_t OP_AND_IMM = 8'h29;
	localparam byte_t OP_ORA_IMM = 8'h09;
	localparam byte_t OP_EOR_IMM = 8'h49;

	// Implied
	localparam byte_t OP_TAX     = 8'hAA;
	localparam byte_t OP_TAY     = 8'hA8;
	localparam byte_t OP_INX     = 8'hE8;
	localparam byte_t OP_INY     = 8'hC8;
	localparam byte_t OP_CLC     = 8'h18;
	localparam byte_t OP_SEC     = 8'h38;
	localparam byte_t OP_NOP     = 8'hEA;

	// Absolute stores and jump
	localparam byte_t OP_STA_ABS = 8'h8D;
	localparam byte_t OP_STX_ABS = 8'h8E;
	localparam byte_t OP_STY_ABS = 8'h8C;
	localparam byte_t OP_JMP_ABS = 8'h4C;

	//////////////////////////////////////////////////////////////////////
	// Control encodings
	//////////////////////////////////////////////////////////////////////

	// Shape of the cycle sequence after the opcode fetch
	typedef enum logic [1:0] {
		CLS_IMPLIED,
		CLS_IMM,
		CLS_STORE_ABS,
		CLS_JMP_ABS
	} instr_class_e;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADC,
		ALU_AND,
		ALU_ORA,
		ALU_EOR,
		ALU_INC
	} alu_op_e;

	// REG_IMM is the operand byte read in the execute cycle
	typedef enum logic [1:0] {
		REG_A,
		REG_X,
		REG_Y,
		REG_IMM
	} reg_sel_e;

	typedef enum logic [1:0] {
		CARRY_KEEP,
		CARRY_ALU,
		CARRY_CLEAR,
		CARRY_SET
	} carry_ctl_e;

	typedef enum logic [1:0] {
		ST_OPCODE,
		ST_OPERAND_LO,
		ST_OPERAND_HI,
		ST_WRITE
	} cpu_state_e;

	// Decoded instruction in 12 bits
	typedef struct packed {
		instr_class_e cls;
		alu_op_e      alu_op;
		reg_sel_e     src_sel;
		reg_sel_e     dst_sel;
		logic         reg_write;
		carry_ctl_e   carry_ctl;
	} micro_ctrl_t;

	// One access per cycle that reads when we is low
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;
	} mem_bus_t;

endpackage

`default_nettype wire
